//--- sim.f
+incdir+.
io_ctrl_pkg.sv
io_sync.sv
debug_serial_router.sv
imem_loader.sv
mode_ctrl.sv
clock_ctrl.sv
io_ctrl_top.sv
io_ctrl_tb.sv

//--- Bender.yml
package:
  name: io_ctrl

sources:
  - io_ctrl_pkg.sv
  - io_sync.sv
  - debug_serial_router.sv
  - imem_loader.sv
  - mode_ctrl.sv
  - clock_ctrl.sv
  - io_ctrl_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - io_ctrl_tb.sv

//--- io_ctrl_ref.svh
`ifndef io_ctrl_ref_svh
`define io_ctrl_ref_svh

// Bus seen by one pattern buffer, high_side picks which buffer
function automatic io_ctrl_pkg::serial_bus_t routed_bus(input io_ctrl_pkg::mode_t mode,
		input io_ctrl_pkg::io_byte_t pa, input logic high_side);
	io_ctrl_pkg::serial_bus_t bus;
	bus = '0;
	if (mode == io_ctrl_pkg::mode_debug && pa[6] == high_side) begin
		bus.sclk  = pa[0];
		bus.ssel  = pa[1];
		bus.sin   = pa[2];
		bus.saddr = pa[5:3];
	end
	return bus;
endfunction

// Debug puts ones on the low nibble and the serial return on bit 4
function automatic io_ctrl_pkg::io_byte_t port_b_drive(input io_ctrl_pkg::mode_t mode,
		input io_ctrl_pkg::io_byte_t core, input io_ctrl_pkg::io_byte_t pa,
		input logic s_low, input logic s_high);
	io_ctrl_pkg::io_byte_t pb;
	pb = core;
	if (mode == io_ctrl_pkg::mode_debug) begin
		pb[3:0] = 4'hf;
		pb[4]   = pa[6] ? s_high : s_low;
	end
	return pb;
endfunction

// Returned as {pat, buffer high, buffer low}
function automatic logic [2:0] pattern_resets(input io_ctrl_pkg::mode_t mode,
		input io_ctrl_pkg::io_byte_t pb);
	if (mode == io_ctrl_pkg::mode_reset || mode == io_ctrl_pkg::mode_memload) begin
		return 3'b111;
	end
	return (mode == io_ctrl_pkg::mode_debug) ? pb[2:0] : 3'b000;
endfunction

// Address is the top 10 of the last 58 bits shifted in
function automatic io_ctrl_pkg::imem_addr_t imem_addr_of(input logic [63:0] shifted);
	return shifted[57:48];
endfunction

// Two 23 bit halves with bits 47 and 23 left out
function automatic io_ctrl_pkg::imem_word_t imem_word_of(input logic [63:0] shifted);
	return {shifted[46:24], shifted[22:0]};
endfunction

`endif

//--- io_ctrl_tb.sv
`default_nettype none

module io_ctrl_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                     clk_int;
	logic                     mode_is_reset;
	io_ctrl_pkg::mode_t       mode_sel;
	io_ctrl_pkg::io_byte_t    port_a_in;
	io_ctrl_pkg::io_byte_t    port_b_in;
	io_ctrl_pkg::io_byte_t    core_out;
	logic                     pwm_low;
	logic                     pwm_high;
	logic                     sout_low;
	logic                     sout_high;
	io_ctrl_pkg::io_byte_t    port_b_out;
	io_ctrl_pkg::io_byte_t    port_a_sync;
	io_ctrl_pkg::serial_bus_t serial_low;
	io_ctrl_pkg::serial_bus_t serial_high;
	io_ctrl_pkg::imem_wr_t    imem_wr;
	logic                     port_b_lsb_oe;
	logic                     pwm_low_sync;
	logic                     pwm_high_sync;
	logic                     reset_pat;
	logic                     reset_patternbuf_low;
	logic                     reset_patternbuf_high;
	logic                     pat_clock_division;
	logic                     clock_out;

	integer      seed = 27319;
	int          check_count = 0;
	int          error_count = 0;
	int          timeout_count = 0;
	logic        compare_on = 1'b0;
	logic [63:0] shifted;
	int          high_len;
	int          low_len;
	logic [9:0]  pads_d1 = '0;
	logic [9:0]  pads_d2 = '0;

	`include "io_ctrl_ref.svh"

	io_ctrl_top dut0 (.*);

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] want);
		check_count++;
		assert (got === want) else begin
			error_count++;
			$display("Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic randomize_pads();
		logic [31:0] rnd;
		rnd = $random(seed);
		port_a_in = rnd[7:0];
		port_b_in = rnd[15:8];
		core_out  = rnd[23:16];
		sout_low  = rnd[24];
		sout_high = rnd[25];
		pwm_low   = rnd[26];
		pwm_high  = rnd[27];
	endtask

	// Picks the DUT output under watch by name
	function automatic logic [63:0] watched(input string name);
		return (name == "pat_clock_division") ? pat_clock_division :
		       (name == "imem_wr.addr") ? imem_wr.addr :
		       (name == "imem_wr.data") ? imem_wr.data :
		       (name == "imem_wr.write") ? imem_wr.write : clock_out;
	endfunction

	task automatic await_value(input string name, input logic [63:0] want, input int limit);
		int cycles;
		cycles = 0;
		while (watched(name) !== want && cycles < limit) begin
			@(negedge clk_int);
			cycles++;
		end
		check_count++;
		assert (watched(name) === want) else begin
			timeout_count++;
			$display("Timeout: %s did not reach 0x%0h within %0d cycles", name, want, limit);
		end
	endtask

	// Counts falling edges while clock_out stays at level
	task automatic measure_phase(input logic level, output int cycles);
		cycles = 0;
		while (clock_out === level && cycles < 40) begin
			cycles++;
			@(negedge clk_int);
		end
	endtask

	task automatic compare_outputs();
		logic [2:0] resets;
		resets = pattern_resets(mode_sel, port_b_in);
		check_value("serial_low", serial_low, routed_bus(mode_sel, port_a_in, 1'b0));
		check_value("serial_high", serial_high, routed_bus(mode_sel, port_a_in, 1'b1));
		check_value("port_b_out", port_b_out,
		            port_b_drive(mode_sel, core_out, port_a_in, sout_low, sout_high));
		check_value("port_b_lsb_oe", port_b_lsb_oe, mode_sel == io_ctrl_pkg::mode_run);
		check_value("reset_pat", reset_pat, resets[2]);
		check_value("reset_patternbuf_high", reset_patternbuf_high, resets[1]);
		check_value("reset_patternbuf_low", reset_patternbuf_low, resets[0]);
	endtask

	initial begin
		clk_int = 1'b0;
		forever #4 clk_int = ~clk_int;
	end

	// Inputs change on the falling edge so the rising edge sees settled outputs
	always @(posedge clk_int) begin
		// Pad values as the synchronizer captures them
		pads_d2 = pads_d1;
		pads_d1 = {pwm_high, pwm_low, port_a_in};
		if (compare_on) begin
			compare_outputs();
		end
	end

	// Synchronized pads lag the raw pads by two rising edges
	always @(negedge clk_int) begin
		if (compare_on) begin
			check_value("port_a_sync", port_a_sync, pads_d2[7:0]);
			check_value("pwm_low_sync", pwm_low_sync, pads_d2[8]);
			check_value("pwm_high_sync", pwm_high_sync, pads_d2[9]);
		end
	end

	initial begin
		int i;
		mode_is_reset = 1'b1;
		mode_sel      = io_ctrl_pkg::mode_reset;
		port_a_in     = '0;
		port_b_in     = '0;
		core_out      = '0;
		pwm_low       = 1'b0;
		pwm_high      = 1'b0;
		sout_low      = 1'b0;
		sout_high     = 1'b0;
		repeat (5) @(negedge clk_int);
		mode_is_reset = 1'b0;
		@(negedge clk_int);
		check_value("pat_clock_division", pat_clock_division, 1);
		check_value("reset_pat", reset_pat, 1);
		check_value("reset_patternbuf_low", reset_patternbuf_low, 1);
		check_value("reset_patternbuf_high", reset_patternbuf_high, 1);
		check_value("imem_wr.write", imem_wr.write, 0);
		check_value("serial_low", serial_low, 0);
		check_value("serial_high", serial_high, 0);
		check_value("port_b_lsb_oe", port_b_lsb_oe, 0);
		check_value("clock_out", clock_out, 0);
		compare_on = 1'b1;

		mode_sel = io_ctrl_pkg::mode_debug;
		for (i = 0; i < 40; i++) begin
			randomize_pads();
			@(negedge clk_int);
		end
		// Division register tracks port B bit 3 one cycle late
		for (i = 0; i < 8; i++) begin
			randomize_pads();
			await_value("pat_clock_division", port_b_in[3], 2);
			@(negedge clk_int);
		end

		port_b_in = '0;
		mode_sel  = io_ctrl_pkg::mode_memload;
		repeat (4) @(negedge clk_int);
		shifted = '0;
		for (i = 0; i < 8; i++) begin
			randomize_pads();
			port_b_in[1:0] = 2'b00;
			repeat (6) @(negedge clk_int);
			port_b_in[0] = 1'b1;
			repeat (6) @(negedge clk_int);
			shifted = {shifted[55:0], port_a_in};
		end
		await_value("imem_wr.addr", imem_addr_of(shifted), 8);
		await_value("imem_wr.data", imem_word_of(shifted), 8);
		port_b_in[1] = 1'b1;
		await_value("imem_wr.write", 1, 4);
		port_b_in[1] = 1'b0;
		await_value("imem_wr.write", 0, 4);

		mode_sel = io_ctrl_pkg::mode_run;
		for (i = 0; i < 20; i++) begin
			randomize_pads();
			@(negedge clk_int);
		end

		// Find a rising clock_out, then time both phases
		await_value("clock_out", 0, 40);
		await_value("clock_out", 1, 40);
		measure_phase(1'b1, high_len);
		measure_phase(1'b0, low_len);
		check_value("clock_out high cycles", high_len, 16);
		check_value("clock_out low cycles", low_len, 16);

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
		         check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- io_ctrl_top.sv
`default_nettype none

module io_ctrl_top (
	input  wire                         clk_int,
	input  wire                         mode_is_reset,
	input  wire io_ctrl_pkg::mode_t     mode_sel,
	input  wire io_ctrl_pkg::io_byte_t  port_a_in,
	input  wire io_ctrl_pkg::io_byte_t  port_b_in,
	input  wire                         pwm_low,
	input  wire                         pwm_high,
	input  wire                         sout_low,
	input  wire                         sout_high,
	input  wire io_ctrl_pkg::io_byte_t  core_out,
	output wire io_ctrl_pkg::io_byte_t  port_b_out,
	output wire                         port_b_lsb_oe,
	output wire io_ctrl_pkg::serial_bus_t serial_low,
	output wire io_ctrl_pkg::serial_bus_t serial_high,
	output wire io_ctrl_pkg::imem_wr_t  imem_wr,
	output wire io_ctrl_pkg::io_byte_t  port_a_sync,
	output wire                         pwm_low_sync,
	output wire                         pwm_high_sync,
	output wire                         reset_pat,
	output wire                         reset_patternbuf_low,
	output wire                         reset_patternbuf_high,
	output wire                         pat_clock_division,
	output wire                         clock_out
);

	// Port A, load clock, load write, pwm low, pwm high
	localparam int sync_width = 12;
	localparam int div_bits   = 5;

	logic [sync_width-1:0] pad_raw;
	logic [sync_width-1:0] pad_sync;
	logic                  sout;

	assign pad_raw = {pwm_high, pwm_low, port_b_in[1], port_b_in[0], port_a_in};

	io_sync #(
		.width(sync_width)
	) u_io_sync (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.async_in      (pad_raw),
		.sync_out      (pad_sync)
	);

	assign port_a_sync   = pad_sync[7:0];
	assign pwm_low_sync  = pad_sync[10];
	assign pwm_high_sync = pad_sync[11];

	// Serial bus is a slow bit-banged interface, raw port A is used directly
	debug_serial_router u_debug_serial_router (
		.mode_sel    (mode_sel),
		.port_a_in   (port_a_in),
		.sout_low    (sout_low),
		.sout_high   (sout_high),
		.serial_low  (serial_low),
		.serial_high (serial_high),
		.sout        (sout)
	);

	imem_loader u_imem_loader (
		.clk_int         (clk_int),
		.mode_is_reset   (mode_is_reset),
		.mode_sel        (mode_sel),
		.port_a_sync     (pad_sync[7:0]),
		.load_clk_sync   (pad_sync[8]),
		.load_write_sync (pad_sync[9]),
		.imem_wr         (imem_wr)
	);

	mode_ctrl u_mode_ctrl (
		.mode_sel              (mode_sel),
		.port_b_in             (port_b_in),
		.core_out              (core_out),
		.sout                  (sout),
		.port_b_out            (port_b_out),
		.port_b_lsb_oe         (port_b_lsb_oe),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high)
	);

	clock_ctrl #(
		.div_bits(div_bits)
	) u_clock_ctrl (
		.clk_int            (clk_int),
		.mode_is_reset      (mode_is_reset),
		.mode_sel           (mode_sel),
		.division_req       (port_b_in[3]),
		.clock_out          (clock_out),
		.pat_clock_division (pat_clock_division)
	);

endmodule

`default_nettype wire

//--- clock_ctrl.sv
`default_nettype none

module clock_ctrl #(
	parameter int div_bits = 5
) (
	input  wire                     clk_int,
	input  wire                     mode_is_reset,
	input  wire io_ctrl_pkg::mode_t mode_sel,
	input  wire                     division_req,
	output logic                    clock_out,
	output logic                    pat_clock_division
);

	logic [div_bits-1:0] div_cnt;

	// Free running, top bit gives a 50 percent duty output clock
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign clock_out = div_cnt[div_bits-1];

	// Division defaults on, debug mode can change it from port B
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			pat_clock_division <= 1'b1;
		end else if (mode_sel == io_ctrl_pkg::mode_reset) begin
			pat_clock_division <= 1'b1;
		end else if (mode_sel == io_ctrl_pkg::mode_debug) begin
			pat_clock_division <= division_req;
		end
	end

endmodule

`default_nettype wire

//--- mode_ctrl.sv
`default_nettype none

module mode_ctrl (
	input  wire io_ctrl_pkg::mode_t     mode_sel,
	input  wire io_ctrl_pkg::io_byte_t  port_b_in,
	input  wire io_ctrl_pkg::io_byte_t  core_out,
	input  wire                         sout,
	output io_ctrl_pkg::io_byte_t       port_b_out,
	output logic                        port_b_lsb_oe,
	output logic                        reset_pat,
	output logic                        reset_patternbuf_low,
	output logic                        reset_patternbuf_high
);

	logic debug_mode;
	logic run_mode;
	logic hold_reset;

	assign debug_mode = (mode_sel == io_ctrl_pkg::mode_debug);
	assign run_mode   = (mode_sel == io_ctrl_pkg::mode_run);

	// Core and both buffers stay in reset while the memory is loaded
	assign hold_reset = (mode_sel == io_ctrl_pkg::mode_reset) ||
	                    (mode_sel == io_ctrl_pkg::mode_memload);

	// Debug lets port B bits 0 to 2 pulse individual resets
	assign reset_pat             = hold_reset | (debug_mode & port_b_in[2]);
	assign reset_patternbuf_high = hold_reset | (debug_mode & port_b_in[1]);
	assign reset_patternbuf_low  = hold_reset | (debug_mode & port_b_in[0]);

	always_comb begin
		port_b_out = core_out;
		if (debug_mode) begin
			// Lower nibble is input here, drive ones as a pull up
			port_b_out[3:0] = 4'hf;
			// Serial return goes out on bit 4
			port_b_out[4] = sout;
		end
	end

	// Lower nibble only drives in run mode, upper nibble always drives
	assign port_b_lsb_oe = run_mode;

endmodule

`default_nettype wire

//--- imem_loader.sv
`default_nettype none

module imem_loader (
	input  wire                         clk_int,
	input  wire                         mode_is_reset,
	input  wire io_ctrl_pkg::mode_t     mode_sel,
	input  wire io_ctrl_pkg::io_byte_t  port_a_sync,
	input  wire                         load_clk_sync,
	input  wire                         load_write_sync,
	output io_ctrl_pkg::imem_wr_t       imem_wr
);

	localparam int shift_bits = 58;

	logic                  memload_mode;
	logic                  load_clk;
	logic                  load_clk_prev;
	logic [shift_bits-1:0] shifter;

	assign memload_mode = (mode_sel == io_ctrl_pkg::mode_memload);

	// Load clock and strobe only count in memory load mode
	assign load_clk = load_clk_sync & memload_mode;

	// New byte enters at the bottom on each rising load clock
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			load_clk_prev <= 1'b0;
			shifter       <= '0;
		end else begin
			load_clk_prev <= load_clk;
			if (load_clk && !load_clk_prev) begin
				shifter <= {shifter[shift_bits-9:0], port_a_sync};
			end
		end
	end

	// Address on top, then two 24 bit slots holding 23 bit halves
	assign imem_wr.addr  = shifter[57:48];
	assign imem_wr.data  = {shifter[46:24], shifter[22:0]};
	assign imem_wr.write = load_write_sync & memload_mode;

endmodule

`default_nettype wire

//--- debug_serial_router.sv
`default_nettype none

module debug_serial_router (
	input  wire io_ctrl_pkg::mode_t     mode_sel,
	input  wire io_ctrl_pkg::io_byte_t  port_a_in,
	input  wire                         sout_low,
	input  wire                         sout_high,
	output io_ctrl_pkg::serial_bus_t    serial_low,
	output io_ctrl_pkg::serial_bus_t    serial_high,
	output logic                        sout
);

	logic debug_mode;
	logic buf_sel;
	io_ctrl_pkg::serial_bus_t bus;

	assign debug_mode = (mode_sel == io_ctrl_pkg::mode_debug);

	// Buffer select on bit 6, 0 picks the low buffer
	assign buf_sel = debug_mode & port_a_in[6];

	// Pull the serial bus out of port A bits 0 to 5
	always_comb begin
		bus.sclk  = port_a_in[0];
		bus.ssel  = port_a_in[1];
		bus.sin   = port_a_in[2];
		bus.saddr = port_a_in[5:3];
	end

	// Only the selected buffer sees any activity
	always_comb begin
		serial_low  = '0;
		serial_high = '0;
		if (debug_mode) begin
			if (buf_sel) begin
				serial_high = bus;
			end else begin
				serial_low = bus;
			end
		end
	end

	// Return path from whichever buffer is addressed
	assign sout = buf_sel ? sout_high : sout_low;

endmodule

`default_nettype wire

//--- io_sync.sv
`default_nettype none

module io_sync #(
	parameter int width = 8
) (
	input  wire               clk_int,
	input  wire               mode_is_reset,
	input  wire [width-1:0]   async_in,
	output logic [width-1:0]  sync_out
);

	// First stage may go metastable, second stage settles it
	logic [width-1:0] stage1;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			stage1   <= '0;
			sync_out <= '0;
		end else begin
			stage1   <= async_in;
			sync_out <= stage1;
		end
	end

endmodule

`default_nettype wire

//--- io_ctrl_pkg.sv
`default_nettype none

package io_ctrl_pkg;

	// Operating modes as seen on the two mode select pads
	typedef enum logic [1:0] {
		mode_reset   = 2'd0,
		mode_debug   = 2'd1,
		mode_run     = 2'd2,
		mode_memload = 2'd3
	} mode_t;

	// One pad port or the core output byte
	typedef logic [7:0] io_byte_t;

	// Register address on the serial config bus
	typedef logic [2:0] saddr_t;

	// Instruction memory address and word
	typedef logic [9:0] imem_addr_t;
	typedef logic [45:0] imem_word_t;

	// Serial config bus toward one pattern buffer
	// Field order follows port A, so saddr sits in the top bits
	typedef struct packed {
		saddr_t saddr;
		logic   sin;
		logic   ssel;
		logic   sclk;
	} serial_bus_t;

	// Instruction memory write request
	typedef struct packed {
		imem_addr_t addr;
		imem_word_t data;
		logic       write;
	} imem_wr_t;

endpackage

`default_nettype wire
